// ==== src/tmr_time_pkg.sv ====
/*
 * time format of the microsecond timer
 * a time value is a microsecond count above a tick count, and one
 * microsecond is 125 ticks of the 8 ns core clock
 */
package tmr_time_pkg;

    localparam int TIME_W = 48;
    localparam int TICK_W = 7;
    localparam int US_W   = TIME_W - TICK_W;  // 41

    localparam int TICKS_PER_US = 125;  // ticks run 0 .. 124

    // cycle time period loaded at reset, in microseconds
    localparam int DEFAULT_PERIOD_US = 1000;

    typedef struct packed {
        logic [US_W-1:0]   us;    // upper bits
        logic [TICK_W-1:0] tick;  // lower bits, never above 124
    } time_t;

endpackage

// ==== src/tmr_reg_pkg.sv ====
/*
 * timer register map and the structs carried between the register
 * bank, the time base and the trigger table
 */
package tmr_reg_pkg;

    import tmr_time_pkg::*;

    localparam int REG_ADDR_W = 12;
    localparam int REG_DATA_W = 32;

    localparam logic [REG_ADDR_W-1:0] ADDR_LOCAL_TIME_L   = 12'h000;
    localparam logic [REG_ADDR_W-1:0] ADDR_LOCAL_TIME_H   = 12'h001;
    localparam logic [REG_ADDR_W-1:0] ADDR_INTR_INDEX     = 12'h002;
    localparam logic [REG_ADDR_W-1:0] ADDR_OFFSET_EN      = 12'h003;
    localparam logic [REG_ADDR_W-1:0] ADDR_OFFSET_L       = 12'h004;
    localparam logic [REG_ADDR_W-1:0] ADDR_OFFSET_H       = 12'h005;  // bit 16 is the sign
    localparam logic [REG_ADDR_W-1:0] ADDR_CONFIG_EN      = 12'h006;
    localparam logic [REG_ADDR_W-1:0] ADDR_CONFIG_VALUE_L = 12'h007;
    localparam logic [REG_ADDR_W-1:0] ADDR_CONFIG_VALUE_H = 12'h008;
    localparam logic [REG_ADDR_W-1:0] ADDR_CONFIG_INDEX   = 12'h009;
    localparam logic [REG_ADDR_W-1:0] ADDR_CUR_TIME_L     = 12'h00a;
    localparam logic [REG_ADDR_W-1:0] ADDR_CUR_TIME_H     = 12'h00b;
    localparam logic [REG_ADDR_W-1:0] ADDR_TIMER_INTR_EN  = 12'h00e;

    // config index that loads the period rather than a table entry
    localparam logic [REG_DATA_W-1:0] PERIOD_INDEX = '1;

    typedef struct packed {
        logic                    en;
        logic [REG_DATA_W/8-1:0] we;    // byte strobes, all low means read
        logic [REG_ADDR_W-1:0]   addr;
        logic [REG_DATA_W-1:0]   din;
    } reg_req_t;

    typedef struct packed {
        time_t offset;      // magnitude
        logic  offset_neg;  // set to subtract
        time_t period;
    } time_cfg_t;

    typedef struct packed {
        logic                  en;
        logic [REG_DATA_W-1:0] idx;
        time_t                 value;
    } tbl_wr_t;

endpackage

// ==== src/tmr_reg_bank.sv ====
/*
 * timer register bank
 * byte-strobed configuration writes, one-cycle command pulses and a
 * registered read port with snapshots of the upper time halves
 */
module tmr_reg_bank
    import tmr_reg_pkg::*;
    import tmr_time_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                  i_rv_clk,
    input  logic                  i_rv_rst_n,
    input  reg_req_t              i_req,
    input  time_t                 i_local_time,
    input  time_t                 i_cur_time,
    input  logic [REG_DATA_W-1:0] i_fired_count,
    output logic [REG_DATA_W-1:0] o_reg_dout,
    output time_cfg_t             o_cfg,
    output logic                  o_offset_apply,
    output tbl_wr_t               o_tbl_wr,
    output logic                  o_intr_en
);

    localparam int HI_W = TIME_W - REG_DATA_W;  // used bits of a high-half register
    localparam logic [REG_DATA_W-1:0] LAST_INDEX = REG_DATA_W'(TABLE_DEPTH);

    logic                  wr_en;
    logic                  rd_en;
    logic                  cfg_ld;     // write to the config enable register
    logic                  idx_valid;
    logic [REG_DATA_W-1:0] wr_mask;
    logic [REG_DATA_W-1:0] offset_h_mrg;
    logic [REG_DATA_W-1:0] value_h_mrg;

    logic [TIME_W-1:0]     offset_q;
    logic                  offset_neg_q;
    logic [TIME_W-1:0]     period_q;
    logic [TIME_W-1:0]     cfg_value_q;
    logic [REG_DATA_W-1:0] cfg_index_q;
    logic                  intr_en_q;
    logic                  offset_apply_q;
    logic                  period_ld_q;
    logic                  tbl_wr_q;

    logic                  rd_q;
    logic [REG_ADDR_W-1:0] rd_addr_q;
    time_t                 local_snap;
    time_t                 cur_snap;

    function automatic logic [REG_DATA_W-1:0] merge_bytes(
        input logic [REG_DATA_W-1:0] old_val,
        input logic [REG_DATA_W-1:0] new_val,
        input logic [REG_DATA_W-1:0] mask
    );
        return (new_val & mask) | (old_val & ~mask);
    endfunction

    assign wr_en  = i_req.en && (|i_req.we);
    assign rd_en  = i_req.en && !(|i_req.we);
    assign cfg_ld = wr_en && (i_req.addr == ADDR_CONFIG_EN);

    // PERIOD_INDEX lies above any table index, so it never counts as valid
    assign idx_valid = (cfg_index_q != '0) && (cfg_index_q <= LAST_INDEX);

    assign wr_mask = {{8{i_req.we[3]}}, {8{i_req.we[2]}}, {8{i_req.we[1]}}, {8{i_req.we[0]}}};

    assign offset_h_mrg = merge_bytes({{(REG_DATA_W-HI_W-1){1'b0}}, offset_neg_q,
                                       offset_q[TIME_W-1:REG_DATA_W]}, i_req.din, wr_mask);
    assign value_h_mrg  = merge_bytes({{(REG_DATA_W-HI_W){1'b0}},
                                       cfg_value_q[TIME_W-1:REG_DATA_W]}, i_req.din, wr_mask);

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            offset_q     <= '0;
            offset_neg_q <= 1'b0;
            cfg_value_q  <= '0;
            cfg_index_q  <= '0;
            intr_en_q    <= 1'b0;
        end else if (wr_en) begin
            case (i_req.addr)
                ADDR_OFFSET_L: begin
                    offset_q[REG_DATA_W-1:0] <= merge_bytes(offset_q[REG_DATA_W-1:0],
                                                            i_req.din, wr_mask);
                end
                ADDR_OFFSET_H: begin
                    offset_q[TIME_W-1:REG_DATA_W] <= offset_h_mrg[HI_W-1:0];
                    offset_neg_q                  <= offset_h_mrg[HI_W];
                end
                ADDR_CONFIG_VALUE_L: begin
                    cfg_value_q[REG_DATA_W-1:0] <= merge_bytes(cfg_value_q[REG_DATA_W-1:0],
                                                               i_req.din, wr_mask);
                end
                ADDR_CONFIG_VALUE_H: cfg_value_q[TIME_W-1:REG_DATA_W] <= value_h_mrg[HI_W-1:0];
                ADDR_CONFIG_INDEX:   cfg_index_q <= merge_bytes(cfg_index_q, i_req.din, wr_mask);
                ADDR_TIMER_INTR_EN:  intr_en_q <= i_req.we[0] ? i_req.din[0] : intr_en_q;
                default: ;
            endcase
        end
    end

    // command pulses, acted on one edge after the request
    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            offset_apply_q <= 1'b0;
            period_ld_q    <= 1'b0;
            tbl_wr_q       <= 1'b0;
            period_q       <= {US_W'(DEFAULT_PERIOD_US), TICK_W'(0)};
        end else begin
            offset_apply_q <= wr_en && (i_req.addr == ADDR_OFFSET_EN) &&
                              i_req.we[0] && i_req.din[0];
            period_ld_q    <= cfg_ld && (cfg_index_q == PERIOD_INDEX);
            tbl_wr_q       <= cfg_ld && idx_valid;
            if (period_ld_q) begin
                period_q <= cfg_value_q;
            end
        end
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= rd_en;
        end
    end

    always_ff @(posedge i_rv_clk) begin
        rd_addr_q <= i_req.addr;
        if (rd_q && (rd_addr_q == ADDR_LOCAL_TIME_L)) local_snap <= i_local_time;
        if (rd_q && (rd_addr_q == ADDR_CUR_TIME_L))   cur_snap   <= i_cur_time;
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            o_reg_dout <= '0;
        end else if (rd_q) begin
            case (rd_addr_q)
                ADDR_LOCAL_TIME_L: o_reg_dout <= i_local_time[REG_DATA_W-1:0];
                ADDR_LOCAL_TIME_H: o_reg_dout <= REG_DATA_W'(local_snap[TIME_W-1:REG_DATA_W]);
                ADDR_INTR_INDEX:   o_reg_dout <= i_fired_count;
                ADDR_CUR_TIME_L:   o_reg_dout <= i_cur_time[REG_DATA_W-1:0];
                ADDR_CUR_TIME_H:   o_reg_dout <= REG_DATA_W'(cur_snap[TIME_W-1:REG_DATA_W]);
                default:           o_reg_dout <= '0;  // write-only or unmapped
            endcase
        end
    end

    assign o_cfg.offset     = offset_q;
    assign o_cfg.offset_neg = offset_neg_q;
    assign o_cfg.period     = period_q;
    assign o_offset_apply   = offset_apply_q;
    assign o_tbl_wr.en      = tbl_wr_q;
    assign o_tbl_wr.idx     = cfg_index_q;  // index and value are stable until the pulse
    assign o_tbl_wr.value   = cfg_value_q;
    assign o_intr_en        = intr_en_q;

endmodule

// ==== src/tmr_time_base.sv ====
/*
 * timer time base
 * free-running local time with one-shot offset correction, and a
 * cycle time counter that wraps at the programmed period
 */
module tmr_time_base
    import tmr_reg_pkg::*;
    import tmr_time_pkg::*;
(
    input  logic      i_rv_clk,
    input  logic      i_rv_rst_n,
    input  logic      i_run,
    input  time_cfg_t i_cfg,
    input  logic      i_offset_apply,
    output time_t     o_local_time,
    output time_t     o_cur_time
);

    localparam int SUM_W = TICK_W + 2;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_US - 1);
    localparam logic [SUM_W-1:0]  TPU       = SUM_W'(TICKS_PER_US);

    time_t            local_q;
    time_t            cur_q;
    time_t            local_adj;  // local time after the offset
    logic             cur_wrap;
    logic [SUM_W-1:0] tick_sum;   // tick + offset tick + 1
    logic [SUM_W-1:0] tick_dif;   // tick - offset tick + 1, biased by one microsecond

    function automatic time_t step_time(input time_t t);
        time_t n;
        n = t;
        if (t.tick == TICK_LAST) begin
            n.tick = '0;
            n.us   = t.us + US_W'(1);
        end else begin
            n.tick = t.tick + TICK_W'(1);
        end
        return n;
    endfunction

    assign tick_sum = SUM_W'(local_q.tick) + SUM_W'(i_cfg.offset.tick) + SUM_W'(1);
    assign tick_dif = SUM_W'(local_q.tick) + TPU + SUM_W'(1) - SUM_W'(i_cfg.offset.tick);

    // mixed-radix add or subtract, the extra tick covers the cycle spent applying it
    always_comb begin
        local_adj = local_q;
        if (!i_cfg.offset_neg) begin
            if (tick_sum >= TPU) begin  // carry into the microseconds
                local_adj.tick = TICK_W'(tick_sum - TPU);
                local_adj.us   = local_q.us + i_cfg.offset.us + US_W'(1);
            end else begin
                local_adj.tick = TICK_W'(tick_sum);
                local_adj.us   = local_q.us + i_cfg.offset.us;
            end
        end else if (tick_dif >= 2 * TPU) begin
            local_adj.tick = '0;  // the added tick rolls over
            local_adj.us   = local_q.us - i_cfg.offset.us + US_W'(1);
        end else if (tick_dif >= TPU) begin
            local_adj.tick = TICK_W'(tick_dif - TPU);
            local_adj.us   = local_q.us - i_cfg.offset.us;
        end else begin
            local_adj.tick = TICK_W'(tick_dif);
            local_adj.us   = local_q.us - i_cfg.offset.us - US_W'(1);  // borrow
        end
    end

    // also pulls cycle time back in range after a shorter period is loaded
    assign cur_wrap = (cur_q.tick == TICK_LAST) && (cur_q.us >= i_cfg.period.us - US_W'(1));

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            local_q <= '0;
        end else if (i_offset_apply) begin
            local_q <= local_adj;
        end else if (i_run) begin
            local_q <= step_time(local_q);
        end
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            cur_q <= '0;
        end else if (i_run) begin
            if (cur_wrap) begin
                cur_q <= '0;
            end else begin
                cur_q <= step_time(cur_q);
            end
        end
    end

    assign o_local_time = local_q;
    assign o_cur_time   = cur_q;

endmodule

// ==== src/tmr_trigger_table.sv ====
/*
 * time-triggered interrupt table
 * fires a one-cycle pulse when cycle time reaches the current entry,
 * then moves on to the next entry until the period restarts
 */
module tmr_trigger_table
    import tmr_reg_pkg::*;
    import tmr_time_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                  i_rv_clk,
    input  logic                  i_rv_rst_n,
    input  tbl_wr_t               i_tbl_wr,
    input  time_t                 i_cur_time,
    input  logic                  i_run,
    input  logic                  i_hold,
    input  logic                  i_intr_en,
    output logic                  o_intr_pulse,
    output logic [REG_DATA_W-1:0] o_fired_count
);

    localparam int IDX_W = $clog2(TABLE_DEPTH + 2);  // index runs 1 .. TABLE_DEPTH+1
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_US - 1);

    time_t            table_q [1:TABLE_DEPTH];
    time_t            entry;  // current entry, zero past the end
    logic [IDX_W-1:0] idx_q;
    logic             gated;
    logic             hit;
    logic             pulse_q;

    always_comb begin
        if (idx_q <= IDX_W'(TABLE_DEPTH)) begin
            entry = table_q[idx_q];
        end else begin
            entry = '0;
        end
    end

    assign gated = i_hold || !i_run || !i_intr_en;

    // last tick before the entry's microsecond, so the pulse lands on tick 0
    assign hit = (i_cur_time.tick == TICK_LAST) && (i_cur_time.us == entry.us - US_W'(1)) &&
                 (|entry);

    // the register bank only passes indices 1 .. TABLE_DEPTH
    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            for (int i = 1; i <= TABLE_DEPTH; i++) begin
                table_q[i] <= '0;
            end
        end else if (i_tbl_wr.en) begin
            table_q[i_tbl_wr.idx[IDX_W-1:0]] <= i_tbl_wr.value;
        end
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            pulse_q <= 1'b0;
            idx_q   <= IDX_W'(1);
        end else if (gated) begin
            pulse_q <= 1'b0;  // index frozen
        end else if (!(|i_cur_time)) begin
            pulse_q <= 1'b0;  // new period
            idx_q   <= IDX_W'(1);
        end else if (hit) begin
            pulse_q <= 1'b1;
            idx_q   <= idx_q + IDX_W'(1);
        end else begin
            pulse_q <= 1'b0;
        end
    end

    assign o_intr_pulse  = pulse_q;
    assign o_fired_count = REG_DATA_W'(idx_q - IDX_W'(1));

endmodule

// ==== src/tmr_top.sv ====
/*
 * microsecond timer for the RISC-V core
 * register bank, time base and time-triggered interrupt table
 */
module tmr_top
    import tmr_reg_pkg::*;
    import tmr_time_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                    i_rv_clk,
    input  logic                    i_rv_rst_n,
    input  logic [REG_ADDR_W-1:0]   i_reg_addr,
    input  logic [REG_DATA_W-1:0]   i_reg_din,
    input  logic                    i_reg_en,
    input  logic [REG_DATA_W/8-1:0] i_reg_we,
    output logic [REG_DATA_W-1:0]   o_reg_dout,
    input  logic                    i_intr_start,  // core is ready for interrupts
    input  logic                    i_wait_rvrst,  // core reset pending, hold interrupts
    output logic                    o_intr_pulse,
    output logic [TIME_W-1:0]       o_cur_time     // to the TS scheduler
);

    reg_req_t              req;
    time_cfg_t             cfg;
    tbl_wr_t               tbl_wr;
    time_t                 local_time;
    time_t                 cur_time;
    logic                  offset_apply;
    logic                  intr_en;
    logic [REG_DATA_W-1:0] fired_count;

    assign req.en   = i_reg_en;
    assign req.we   = i_reg_we;
    assign req.addr = i_reg_addr;
    assign req.din  = i_reg_din;

    tmr_reg_bank #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_reg_bank (
        .i_rv_clk       (i_rv_clk),
        .i_rv_rst_n     (i_rv_rst_n),
        .i_req          (req),
        .i_local_time   (local_time),
        .i_cur_time     (cur_time),
        .i_fired_count  (fired_count),
        .o_reg_dout     (o_reg_dout),
        .o_cfg          (cfg),
        .o_offset_apply (offset_apply),
        .o_tbl_wr       (tbl_wr),
        .o_intr_en      (intr_en)
    );

    tmr_time_base u_time_base (
        .i_rv_clk       (i_rv_clk),
        .i_rv_rst_n     (i_rv_rst_n),
        .i_run          (i_intr_start),
        .i_cfg          (cfg),
        .i_offset_apply (offset_apply),
        .o_local_time   (local_time),
        .o_cur_time     (cur_time)
    );

    tmr_trigger_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_trigger_table (
        .i_rv_clk      (i_rv_clk),
        .i_rv_rst_n    (i_rv_rst_n),
        .i_tbl_wr      (tbl_wr),
        .i_cur_time    (cur_time),
        .i_run         (i_intr_start),
        .i_hold        (i_wait_rvrst),
        .i_intr_en     (intr_en),
        .o_intr_pulse  (o_intr_pulse),
        .o_fired_count (fired_count)
    );

    assign o_cur_time = cur_time;

endmodule

// ==== tb/tmr_sva.sv ====
/*
 * concurrent checks on the timer outputs
 */
module tmr_sva (
    input logic        i_rv_clk,
    input logic        i_rv_rst_n,
    input logic        i_hold,
    input logic        i_pulse,
    input logic [47:0] i_cur_time,
    input logic [47:0] i_period
);
    timeunit 1ns;
    timeprecision 100ps;

    a_pulse_single: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        i_pulse |=> !i_pulse) else $error("interrupt pulse lasted two cycles");

    // the pulse is registered, so hold shows one cycle later
    a_hold_quiet: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        i_hold |=> !i_pulse) else $error("interrupt pulse while held");

    a_cur_range: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        i_cur_time[47:7] < i_period[47:7]) else $error("cycle time beyond period");

    a_tick_range: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        i_cur_time[6:0] <= 7'd124) else $error("tick field above 124");

endmodule

bind tmr_top tmr_sva u_sva (
    .i_rv_clk   (i_rv_clk),
    .i_rv_rst_n (i_rv_rst_n),
    .i_hold     (i_wait_rvrst),
    .i_pulse    (o_intr_pulse),
    .i_cur_time (o_cur_time),
    .i_period   (cfg.period)
);

// ==== tb/tmr_tb.sv ====
/*
 * testbench for the microsecond timer
 * random register traffic and run gaps, checked cycle by cycle
 * against a reference model of the timer
 */
module tmr_tb
    import tmr_reg_pkg::*;
    import tmr_time_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int  DEPTH      = 16;
    localparam int  ROUNDS     = 4;
    localparam int  RUN_CYCLES = 3000;
    localparam real TIMEOUT_NS = ROUNDS * (RUN_CYCLES + 2500) * 40.0 + 20000.0;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [11:0] reg_addr;
    logic [31:0] reg_din;
    logic        reg_en;
    logic [3:0]  reg_we;
    logic [31:0] reg_dout;
    logic        run;
    logic        hold;
    logic        pulse;
    logic [47:0] cur_time;

    // reference model state
    logic [47:0] m_local, m_cur, m_period, m_lsnap, m_csnap;
    logic [47:0] m_table [1:DEPTH];
    logic [31:0] m_off_lo, m_off_hi, m_val_lo, m_val_hi, m_cfg_idx, m_dout;
    logic [11:0] m_rd_addr;
    logic        m_rd, m_apply, m_per_pend, m_tbl_pend, m_intr_en, m_pulse;
    int          m_idx;
    int          pulse_count = 0;

    tmr_top #(
        .TABLE_DEPTH (DEPTH)
    ) UUT (
        .i_rv_clk     (clk),
        .i_rv_rst_n   (rst_n),
        .i_reg_addr   (reg_addr),
        .i_reg_din    (reg_din),
        .i_reg_en     (reg_en),
        .i_reg_we     (reg_we),
        .o_reg_dout   (reg_dout),
        .i_intr_start (run),
        .i_wait_rvrst (hold),
        .o_intr_pulse (pulse),
        .o_cur_time   (cur_time)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else report_failure($sformatf("ERROR t=%0t %s expected=%h got=%h",
                                                           $time, name, exp, got));
    endtask

    function automatic logic [63:0] to_ticks(input logic [47:0] t);
        return 64'(t[47:7]) * 125 + 64'(t[6:0]);
    endfunction

    function automatic logic [47:0] from_ticks(input logic [63:0] n);
        logic [63:0] us;
        us = n / 125;
        return {us[40:0], 7'(n % 125)};
    endfunction

    function automatic logic [47:0] next_tick(input logic [47:0] t);
        return from_ticks(to_ticks(t) + 1);
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_val,
                                                  input logic [31:0] new_val,
                                                  input logic [3:0]  we);
        logic [31:0] r;
        r = old_val;
        for (int b = 0; b < 4; b++) begin
            if (we[b]) r[8*b +: 8] = new_val[8*b +: 8];
        end
        return r;
    endfunction

    // model, updated from its own state and the inputs sampled at the edge
    always @(posedge clk) begin
        logic [47:0] entry;
        logic [63:0] off;
        logic        wr;
        if (!rst_n) begin
            m_local    = '0;
            m_cur      = '0;
            m_period   = {41'd1000, 7'd0};
            m_off_lo   = '0;
            m_off_hi   = '0;
            m_val_lo   = '0;
            m_val_hi   = '0;
            m_cfg_idx  = '0;
            m_dout     = '0;
            m_rd       = 0;
            m_apply    = 0;
            m_per_pend = 0;
            m_tbl_pend = 0;
            m_intr_en  = 0;
            m_pulse    = 0;
            m_idx      = 1;
            for (int i = 1; i <= DEPTH; i++) m_table[i] = '0;
        end else begin
            if (m_rd) begin
                case (m_rd_addr)
                    ADDR_LOCAL_TIME_L: m_dout = m_local[31:0];
                    ADDR_LOCAL_TIME_H: m_dout = {16'h0, m_lsnap[47:32]};
                    ADDR_INTR_INDEX:   m_dout = 32'(m_idx - 1);
                    ADDR_CUR_TIME_L:   m_dout = m_cur[31:0];
                    ADDR_CUR_TIME_H:   m_dout = {16'h0, m_csnap[47:32]};
                    default:           m_dout = '0;
                endcase
                if (m_rd_addr == ADDR_LOCAL_TIME_L) m_lsnap = m_local;
                if (m_rd_addr == ADDR_CUR_TIME_L) m_csnap = m_cur;
            end
            m_rd      = reg_en && (reg_we == 4'h0);
            m_rd_addr = reg_addr;
            entry = (m_idx <= DEPTH) ? m_table[m_idx] : '0;
            if (hold || !run || !m_intr_en) begin
                m_pulse = 0;
            end else if (m_cur == '0) begin
                m_pulse = 0;
                m_idx   = 1;
            end else if (entry != '0 && m_cur[6:0] == 7'd124 &&
                         41'(m_cur[47:7] + 41'd1) == entry[47:7]) begin
                m_pulse = 1;  // next tick is the entry's microsecond with tick 0
                m_idx   = m_idx + 1;
            end else begin
                m_pulse = 0;
            end
            off = to_ticks({m_off_hi[15:0], m_off_lo});
            if (m_apply) begin
                m_local = m_off_hi[16] ? from_ticks(to_ticks(m_local) - off + 1)
                                       : from_ticks(to_ticks(m_local) + off + 1);
            end else if (run) begin
                m_local = next_tick(m_local);
            end
            if (run) begin
                if (m_cur[6:0] == 7'd124 && 41'(m_cur[47:7] + 41'd1) == m_period[47:7])
                    m_cur = '0;
                else
                    m_cur = next_tick(m_cur);
            end
            if (m_tbl_pend) m_table[m_cfg_idx] = {m_val_hi[15:0], m_val_lo};
            if (m_per_pend) m_period = {m_val_hi[15:0], m_val_lo};
            wr = reg_en && (reg_we != 4'h0);
            m_apply    = wr && reg_addr == ADDR_OFFSET_EN && reg_we[0] && reg_din[0];
            m_per_pend = wr && reg_addr == ADDR_CONFIG_EN && m_cfg_idx == 32'hffff_ffff;
            m_tbl_pend = wr && reg_addr == ADDR_CONFIG_EN && m_cfg_idx >= 1 && m_cfg_idx <= DEPTH;
            if (wr) begin
                case (reg_addr)
                    ADDR_OFFSET_L:       m_off_lo = apply_strobes(m_off_lo, reg_din, reg_we);
                    ADDR_OFFSET_H:       m_off_hi = apply_strobes(m_off_hi, reg_din, reg_we) &
                                                    32'h1_ffff;
                    ADDR_CONFIG_VALUE_L: m_val_lo = apply_strobes(m_val_lo, reg_din, reg_we);
                    ADDR_CONFIG_VALUE_H: m_val_hi = apply_strobes(m_val_hi, reg_din, reg_we) &
                                                    32'hffff;
                    ADDR_CONFIG_INDEX:   m_cfg_idx = apply_strobes(m_cfg_idx, reg_din, reg_we);
                    ADDR_TIMER_INTR_EN:  if (reg_we[0]) m_intr_en = reg_din[0];
                    default: ;
                endcase
            end
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("o_cur_time", 64'(cur_time), 64'(m_cur));
            check_value("o_intr_pulse", 64'(pulse), 64'(m_pulse));
            check_value("o_reg_dout", 64'(reg_dout), 64'(m_dout));
            if (pulse) pulse_count++;
        end
    end

    task automatic cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] we);
        reg_en   = 1;
        reg_we   = we;
        reg_addr = addr;
        reg_din  = data;
        cycle();
        reg_en = 0;
        reg_we = 4'h0;
    endtask

    task automatic read_reg(input logic [11:0] addr);
        reg_en   = 1;
        reg_we   = 4'h0;
        reg_addr = addr;
        cycle();
        reg_en = 0;
    endtask

    task automatic load_config(input logic [31:0] idx, input logic [47:0] value);
        write_reg(ADDR_CONFIG_VALUE_L, value[31:0], 4'hf);
        write_reg(ADDR_CONFIG_VALUE_H, {16'h0, value[47:32]}, 4'hf);
        write_reg(ADDR_CONFIG_INDEX, idx, 4'hf);
        write_reg(ADDR_CONFIG_EN, 32'h1, 4'hf);
    endtask

    task automatic run_traffic(input int n);
        for (int c = 0; c < n; c++) begin
            run  = ($urandom % 8) != 0;
            hold = ($urandom % 16) == 0;
            case ($urandom % 6)
                0: begin
                    read_reg(ADDR_LOCAL_TIME_L);
                    read_reg(ADDR_LOCAL_TIME_H);
                end
                1: begin
                    read_reg(ADDR_CUR_TIME_L);
                    read_reg(ADDR_CUR_TIME_H);
                end
                2: read_reg(ADDR_INTR_INDEX);
                3: write_reg(ADDR_TIMER_INTR_EN, {31'h0, ($urandom % 6) != 0}, 4'h1);
                default: cycle();
            endcase
        end
        run  = 1;
        hold = 0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        report_failure("run timed out waiting for the tests to finish");
    end

    initial begin
        int          period_us;
        int          n_entries;
        int          us;
        logic [3:0]  strobe;
        logic [31:0] mask;
        logic [31:0] junk;
        logic [31:0] target;
        void'($urandom(32'hfddf));
        rst_n    = 0;
        reg_addr = '0;
        reg_din  = '0;
        reg_en   = 0;
        reg_we   = 4'h0;
        run      = 0;
        hold     = 0;
        repeat (5) cycle();
        rst_n = 1;
        cycle();
        run = 1;
        write_reg(ADDR_TIMER_INTR_EN, 32'h1, 4'h1);
        for (int r = 0; r < ROUNDS; r++) begin
            period_us = $urandom_range(3, 6);
            write_reg(ADDR_CONFIG_VALUE_L, 32'(period_us) << 7, 4'hf);
            write_reg(ADDR_CONFIG_VALUE_H, 32'h0, 4'hf);
            write_reg(ADDR_CONFIG_INDEX, 32'hffff_ffff, 4'hf);
            // load the period early in a period so cycle time stays in range
            while (cur_time[47:7] != '0 || cur_time[6:0] > 7'd60) cycle();
            write_reg(ADDR_CONFIG_EN, 32'h1, 4'hf);
            n_entries = $urandom_range(1, period_us - 1);
            us = 0;
            for (int i = 1; i <= n_entries; i++) begin
                us = us + 1;
                load_config(i, {41'(us), 7'd0});
            end
            load_config(n_entries + 1, '0);  // end of the list
            run_traffic(RUN_CYCLES / 2);
            // partial strobes on one entry, each byte only right from the write that strobes it
            strobe = 4'($urandom_range(1, 14));
            mask   = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
            junk   = $urandom | 32'h0101_0101;  // no byte of it is zero
            target = {25'($urandom_range(1, period_us - 1)), 7'd0};
            write_reg(ADDR_CONFIG_VALUE_L, target ^ (junk & mask), 4'hf);
            write_reg(ADDR_CONFIG_VALUE_L, target ^ (junk & ~mask), strobe);
            write_reg(ADDR_CONFIG_INDEX, $urandom_range(1, n_entries), 4'hf);
            write_reg(ADDR_CONFIG_EN, 32'h1, 4'hf);
            run_traffic(RUN_CYCLES / 4);
            write_reg(ADDR_OFFSET_L, {25'($urandom_range(0, 2)), 7'($urandom_range(0, 124))},
                      4'hf);
            // positive steps also move the upper half, so its reads carry data
            write_reg(ADDR_OFFSET_H, {15'h0, 1'(r % 2), (r % 2 == 1) ? 16'h0 : 16'($urandom)},
                      4'hf);
            write_reg(ADDR_OFFSET_EN, 32'h1, 4'h1);
            read_reg(ADDR_LOCAL_TIME_L);
            read_reg(ADDR_LOCAL_TIME_H);
            run_traffic(RUN_CYCLES / 4);
        end
        repeat (4) cycle();
        if (pulse_count == 0) begin
            report_failure("no interrupt pulse was seen during the whole run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
src/tmr_time_pkg.sv
src/tmr_reg_pkg.sv
src/tmr_reg_bank.sv
src/tmr_time_base.sv
src/tmr_trigger_table.sv
src/tmr_top.sv
tb/tmr_sva.sv
tb/tmr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tmr_tb
FLIST     ?= vlog.f
LOG       ?= sim.log

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
